/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    // base opcodes of the RV32I subset
    typedef enum logic [6:0] {
        OPCODE_REG    = 7'b0110011,
        OPCODE_IMM    = 7'b0010011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111
    } opcode_t;

    // funct3 for REG and IMM
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_SUB_SRA = 7'b0100000; // alternate op bit 30

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_func_t;

    typedef enum logic [2:0] {
        SEXT_I, SEXT_S, SEXT_B, SEXT_J, SEXT_U
    } sext_ctrl_t;

    typedef enum logic [1:0] {
        PC_INC, // sequential
        PC_BR,  // conditional branch
        PC_JAL  // jal or jalr
    } pc_source_t;

endpackage

/* logic/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
    logic                   mem_to_reg; // load data to rd
    logic                   reg_write;
    logic                   mem_write;
    logic                   mem_read;
    logic                   jal;        // link value to rd
    logic                   lui;        // immediate to rd
    rv_pkg::alu_ctrl_t      alu_ctrl;
    logic                   alu_pc;     // pc as operand a
    logic                   alu_imm;    // imm as operand b
    rv_pkg::br_func_t       br_func;
    logic                   jal_addr;   // 1 for jalr target
    rv_pkg::sext_ctrl_t     sext_op;
    rv_pkg::pc_source_t     pc_source;

    modport decoder (output mem_to_reg, reg_write, mem_write, mem_read, jal, lui,
                     alu_ctrl, alu_pc, alu_imm, br_func, jal_addr, sext_op, pc_source);
    modport exec (input mem_to_reg, mem_write, mem_read, jal, lui,
                  alu_ctrl, alu_pc, alu_imm, br_func);
    modport fetch (input pc_source, jal_addr);
    modport ext (input sext_op);
endinterface

/* logic/control.sv */
`timescale 1ns/1ps

module control (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    ctrl_if.decoder         ctl
);

    logic alt_op; // bit 30 set for sub and sra

    assign alt_op = (funct7 == rv_pkg::FUNCT7_SUB_SRA);

    always_comb begin
        // safe defaults, nothing written
        ctl.mem_to_reg = 1'b0;
        ctl.reg_write  = 1'b0;
        ctl.mem_write  = 1'b0;
        ctl.mem_read   = 1'b0;
        ctl.jal        = 1'b0;
        ctl.lui        = 1'b0;
        ctl.alu_ctrl   = rv_pkg::ALU_ADD;
        ctl.alu_pc     = 1'b0;
        ctl.alu_imm    = 1'b0;
        ctl.br_func    = rv_pkg::BR_NONE;
        ctl.jal_addr   = 1'b0;
        ctl.sext_op    = rv_pkg::SEXT_I;
        ctl.pc_source  = rv_pkg::PC_INC;

        unique case (opcode)
            rv_pkg::OPCODE_REG, rv_pkg::OPCODE_IMM: begin
                ctl.reg_write = 1'b1;
                ctl.alu_imm   = (opcode == rv_pkg::OPCODE_IMM);

                unique case (funct3)
                    rv_pkg::FUNCT3_ADD_SUB: begin
                        // no subi, so imm form always adds
                        if (alt_op && opcode == rv_pkg::OPCODE_REG)
                            ctl.alu_ctrl = rv_pkg::ALU_SUB;
                        else
                            ctl.alu_ctrl = rv_pkg::ALU_ADD;
                    end
                    rv_pkg::FUNCT3_XOR:  ctl.alu_ctrl = rv_pkg::ALU_XOR;
                    rv_pkg::FUNCT3_OR:   ctl.alu_ctrl = rv_pkg::ALU_OR;
                    rv_pkg::FUNCT3_AND:  ctl.alu_ctrl = rv_pkg::ALU_AND;
                    rv_pkg::FUNCT3_SLL:  ctl.alu_ctrl = rv_pkg::ALU_SLL;
                    rv_pkg::FUNCT3_SRL_SRA:
                        ctl.alu_ctrl = alt_op ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::FUNCT3_SLT:  ctl.alu_ctrl = rv_pkg::ALU_SLT;
                    rv_pkg::FUNCT3_SLTU: ctl.alu_ctrl = rv_pkg::ALU_SLTU;
                endcase
            end

            rv_pkg::OPCODE_LOAD: begin
                ctl.mem_to_reg = 1'b1;
                ctl.mem_read   = 1'b1;
                ctl.reg_write  = 1'b1;
                ctl.alu_imm    = 1'b1; // rs1 + offset
            end

            rv_pkg::OPCODE_STORE: begin
                ctl.mem_write = 1'b1;
                ctl.alu_imm   = 1'b1;
                ctl.sext_op   = rv_pkg::SEXT_S;
            end

            rv_pkg::OPCODE_BRANCH: begin
                ctl.pc_source = rv_pkg::PC_BR;
                ctl.sext_op   = rv_pkg::SEXT_B;
                case (funct3)
                    rv_pkg::FUNCT3_BEQ:  ctl.br_func = rv_pkg::BR_BEQ;
                    rv_pkg::FUNCT3_BNE:  ctl.br_func = rv_pkg::BR_BNE;
                    rv_pkg::FUNCT3_BLT:  ctl.br_func = rv_pkg::BR_BLT;
                    rv_pkg::FUNCT3_BGE:  ctl.br_func = rv_pkg::BR_BGE;
                    rv_pkg::FUNCT3_BLTU: ctl.br_func = rv_pkg::BR_BLTU;
                    rv_pkg::FUNCT3_BGEU: ctl.br_func = rv_pkg::BR_BGEU;
                    default:             ctl.br_func = rv_pkg::BR_NONE; // never taken
                endcase
            end

            rv_pkg::OPCODE_JAL: begin
                ctl.pc_source = rv_pkg::PC_JAL;
                ctl.reg_write = 1'b1;
                ctl.jal       = 1'b1;
                ctl.sext_op   = rv_pkg::SEXT_J;
            end

            rv_pkg::OPCODE_JALR: begin
                ctl.pc_source = rv_pkg::PC_JAL;
                ctl.jal_addr  = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.jal       = 1'b1;
                ctl.alu_imm   = 1'b1; // target from rs1 + imm in the alu
            end

            rv_pkg::OPCODE_LUI: begin
                ctl.reg_write = 1'b1;
                ctl.lui       = 1'b1;
                ctl.sext_op   = rv_pkg::SEXT_U;
            end

            rv_pkg::OPCODE_AUIPC: begin
                ctl.reg_write = 1'b1;
                ctl.alu_pc    = 1'b1;
                ctl.alu_imm   = 1'b1;
                ctl.sext_op   = rv_pkg::SEXT_U;
            end

            default: ; // unknown opcode just advances the pc
        endcase
    end

    // a store never writes a register in the same instruction
    assert final (!(ctl.mem_write && ctl.reg_write))
        else $error("control: mem_write and reg_write both set");

endmodule

/* logic/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:0]              instr,
    ctrl_if.ext                      ctl,
    output logic [rv_pkg::xlen-1:0]  imm
);

    logic sign;

    assign sign = instr[31]; // every format takes its sign from bit 31

    always_comb begin
        unique case (ctl.sext_op)
            rv_pkg::SEXT_I:
                imm = {{(rv_pkg::xlen-12){sign}}, instr[31:20]};
            rv_pkg::SEXT_S:
                imm = {{(rv_pkg::xlen-12){sign}}, instr[31:25], instr[11:7]};
            // b and j keep bit 0 at zero
            rv_pkg::SEXT_B:
                imm = {{(rv_pkg::xlen-12){sign}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            rv_pkg::SEXT_J:
                imm = {{(rv_pkg::xlen-20){sign}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            rv_pkg::SEXT_U:
                imm = {instr[31:12], 12'b0};      // upper 20 bits only
            default:
                imm = {{(rv_pkg::xlen-12){sign}}, instr[31:20]};
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     we,
    input  logic [rv_pkg::xlen-1:0]  wd,
    output logic [rv_pkg::xlen-1:0]  rs1_data,
    output logic [rv_pkg::xlen-1:0]  rs2_data
);

    logic [rv_pkg::xlen-1:0] regs [32]; // entry 0 never written

    always_ff @(posedge clk) begin
        if (!reset && we && rd != 5'd0)
            regs[rd] <= wd;
    end

    // combinational reads, x0 forced to zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    assert property (@(posedge clk) rs1 == 5'd0 |-> rs1_data == '0)
        else $error("reg_file: x0 read on port 1 not zero");
    assert property (@(posedge clk) rs2 == 5'd0 |-> rs2_data == '0)
        else $error("reg_file: x0 read on port 2 not zero");

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                     reset,
    ctrl_if.exec                     ctl,
    input  logic [rv_pkg::xlen-1:0]  pc,
    input  logic [rv_pkg::xlen-1:0]  pc_plus4,
    input  logic [rv_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_pkg::xlen-1:0]  rs2_data,
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic [rv_pkg::xlen-1:0]  alu_result,
    output logic [rv_pkg::xlen-1:0]  wb_data,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic                     br_taken,
    output logic                     dmem_we,
    output logic                     dmem_re
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic                    eq;
    logic                    lt;   // signed
    logic                    ltu;

    assign op_a  = ctl.alu_pc  ? pc  : rs1_data;
    assign op_b  = ctl.alu_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (ctl.alu_ctrl)
            rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_SLT:
                alu_result = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:
                alu_result = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
            default:          alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the two registers
    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        unique case (ctl.br_func)
            rv_pkg::BR_BEQ:  br_taken = eq;
            rv_pkg::BR_BNE:  br_taken = !eq;
            rv_pkg::BR_BLT:  br_taken = lt;
            rv_pkg::BR_BGE:  br_taken = !lt;
            rv_pkg::BR_BLTU: br_taken = ltu;
            rv_pkg::BR_BGEU: br_taken = !ltu;
            default:         br_taken = 1'b0; // BR_NONE
        endcase
    end

    // writeback priority jump, lui, load, alu
    always_comb begin
        if (ctl.jal)
            wb_data = pc_plus4;
        else if (ctl.lui)
            wb_data = imm;
        else if (ctl.mem_to_reg)
            wb_data = dmem_rdata;
        else
            wb_data = alu_result;
    end

    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctl.mem_write && !reset; // no memory traffic while in reset
    assign dmem_re    = ctl.mem_read  && !reset;

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     reset,
    ctrl_if.fetch                    ctl,
    input  logic                     br_taken,
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  logic [rv_pkg::xlen-1:0]  alu_result,
    output logic [rv_pkg::xlen-1:0]  pc,
    output logic [rv_pkg::xlen-1:0]  pc_plus4
);

    logic [rv_pkg::xlen-1:0] pc_rel;  // pc + imm for branch and jal
    logic [rv_pkg::xlen-1:0] pc_next;

    assign pc_plus4 = pc + rv_pkg::xlen'(4);
    assign pc_rel   = pc + imm;

    always_comb begin
        unique case (ctl.pc_source)
            rv_pkg::PC_BR:  pc_next = br_taken ? pc_rel : pc_plus4;
            rv_pkg::PC_JAL: pc_next = ctl.jal_addr ? {alu_result[rv_pkg::xlen-1:1], 1'b0}
                                                   : pc_rel;
            default:        pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc_unit: misaligned pc %h", pc);

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     reset,
    // instruction memory, read combinationally
    output logic [rv_pkg::xlen-1:0]  imem_addr,
    input  logic [31:0]              imem_data,
    // data memory
    output logic [rv_pkg::xlen-1:0]  dmem_addr,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic                     dmem_we,
    output logic                     dmem_re,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] wb_data;
    logic                    br_taken;

    ctrl_if ctl ();

    control i_control (
        .opcode (rv_pkg::opcode_t'(imem_data[6:0])),
        .funct3 (imem_data[14:12]),
        .funct7 (imem_data[31:25]),
        .ctl    (ctl.decoder)
    );

    imm_gen i_imm_gen (
        .instr (imem_data),
        .ctl   (ctl.ext),
        .imm   (imm)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (imem_data[19:15]),
        .rs2      (imem_data[24:20]),
        .rd       (imem_data[11:7]),
        .we       (ctl.reg_write),
        .wd       (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute i_execute (
        .reset      (reset),
        .ctl        (ctl.exec),
        .pc         (pc),
        .pc_plus4   (pc_plus4),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .alu_result (alu_result),
        .wb_data    (wb_data),
        .dmem_wdata (dmem_wdata),
        .br_taken   (br_taken),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) i_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .ctl        (ctl.fetch),
        .br_taken   (br_taken),
        .imm        (imm),
        .alu_result (alu_result),
        .pc         (pc),
        .pc_plus4   (pc_plus4)
    );

    assign imem_addr = pc;
    assign dmem_addr = alu_result; // load/store address is rs1 + offset

endmodule

/* test/rv_core_prog.svh */
`ifndef RV_CORE_PROG_SVH
`define RV_CORE_PROG_SVH

logic [31:0] exp_addr [64];
logic [31:0] exp_data [64];
string       exp_name [64];
int          n_exp;
logic [31:0] prog_pc;

// r-type field order, also reused for i, s and b words
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return enc_r(imm[11:5], imm[4:0], rs1, 3'b000, rd, rv_pkg::OPCODE_IMM);
endfunction

task automatic emit(input logic [31:0] word);
    imem[prog_pc[9:2]] = word;
    prog_pc += 4;
endtask

// sw rs into the next result slot at 0x400 + 4 * n
task automatic store_check(input logic [4:0] rs, input logic [31:0] data, input string name,
                           input int src = -1);
    logic [11:0] off;
    off = 12'h400 + 12'(4 * n_exp);
    emit(enc_r(off[11:5], rs, 5'd0, 3'b010, off[4:0], rv_pkg::OPCODE_STORE));
    exp_addr[n_exp] = {20'd0, off};
    exp_data[n_exp] = (src >= 0) ? dmem[src] : data; // copies take the seeded word
    exp_name[n_exp] = name;
    n_exp++;
endtask

task automatic build_program();
    logic [2:0]  alu_f3 [10] = '{rv_pkg::FUNCT3_ADD_SUB, rv_pkg::FUNCT3_ADD_SUB,
                                 rv_pkg::FUNCT3_XOR, rv_pkg::FUNCT3_OR, rv_pkg::FUNCT3_AND,
                                 rv_pkg::FUNCT3_SLL, rv_pkg::FUNCT3_SRL_SRA,
                                 rv_pkg::FUNCT3_SRL_SRA, rv_pkg::FUNCT3_SLT,
                                 rv_pkg::FUNCT3_SLTU};
    logic [6:0]  alu_f7 [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};
    // x1 = -20 and x2 = 6 (or imm 6)
    logic [31:0] alu_res [10] = '{32'hFFFFFFF2, 32'hFFFFFFE6, 32'hFFFFFFEA, 32'hFFFFFFEE,
                                  32'h4, 32'hFFFFFB00, 32'h03FFFFFF, 32'hFFFFFFFF, 1, 0};
    string       alu_name [10] = '{"add", "sub", "xor", "or", "and", "sll", "srl", "sra",
                                   "slt", "sltu"};
    logic [2:0]  br_f3 [6] = '{rv_pkg::FUNCT3_BEQ, rv_pkg::FUNCT3_BNE, rv_pkg::FUNCT3_BLT,
                               rv_pkg::FUNCT3_BGE, rv_pkg::FUNCT3_BLTU, rv_pkg::FUNCT3_BGEU};
    string       br_name [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
    int          br_rs1 [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
    int          br_rs2 [12] = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};
    logic [31:0] pc0;
    prog_pc = RESET_PC;
    n_exp = 0;
    emit(enc_addi(5'd1, 5'd0, 12'hFEC));
    emit(enc_addi(5'd2, 5'd0, 12'd6));
    for (int i = 0; i < 10; i++) begin
        emit(enc_r(alu_f7[i], 5'd2, 5'd1, alu_f3[i], 5'd3, rv_pkg::OPCODE_REG));
        store_check(5'd3, alu_res[i], alu_name[i]);
        if (i != 1) begin // no immediate sub
            emit(enc_r(alu_f7[i], 5'd6, 5'd1, alu_f3[i], 5'd3, rv_pkg::OPCODE_IMM));
            store_check(5'd3, alu_res[i], {alu_name[i], "i"});
        end
    end
    emit({20'h12345, 5'd3, 7'(rv_pkg::OPCODE_LUI)});
    store_check(5'd3, 32'h12345000, "lui");
    pc0 = prog_pc;
    emit({20'h00001, 5'd3, 7'(rv_pkg::OPCODE_AUIPC)});
    store_check(5'd3, pc0 + 32'h1000, "auipc");
    emit(enc_r(7'd0, 5'd16, 5'd0, 3'b010, 5'd4, rv_pkg::OPCODE_LOAD));
    store_check(5'd4, 0, "lw_sw_a", 4);
    emit(enc_r(7'd3, 5'd28, 5'd0, 3'b010, 5'd4, rv_pkg::OPCODE_LOAD));
    store_check(5'd4, 0, "lw_sw_b", 31);
    for (int j = 0; j < 12; j++) begin
        emit(enc_addi(5'd5, 5'd0, 12'(16 * (j / 2) + 1)));   // taken marker
        emit(enc_r(7'd0, 5'(br_rs2[j]), 5'(br_rs1[j]), br_f3[j / 2], 5'b01000,
                   rv_pkg::OPCODE_BRANCH));                   // skip one instruction
        emit(enc_addi(5'd5, 5'd0, 12'(16 * (j / 2) + 2)));   // fall-through marker
        store_check(5'd5, 16 * (j / 2) + ((j % 2 == 0) ? 1 : 2),
                    (j % 2 == 0) ? {br_name[j / 2], "_taken"}
                                 : {br_name[j / 2], "_not_taken"});
    end
    pc0 = prog_pc;
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd6, 7'(rv_pkg::OPCODE_JAL)}); // jal x6, +8
    emit(enc_addi(5'd6, 5'd0, 12'd1));
    store_check(5'd6, pc0 + 4, "jal_link");
    pc0 = prog_pc;
    emit({20'd0, 5'd7, 7'(rv_pkg::OPCODE_AUIPC)});
    emit(enc_r(7'd0, 5'd17, 5'd7, 3'b000, 5'd8, rv_pkg::OPCODE_JALR)); // odd offset
    emit(enc_addi(5'd8, 5'd0, 12'd1));
    emit(enc_addi(5'd8, 5'd0, 12'd2));
    store_check(5'd8, pc0 + 8, "jalr_link");
    emit(enc_addi(5'd0, 5'd0, 12'd5));
    store_check(5'd0, 0, "x0_write");
    emit(32'hFFFF_FFFF); // opcode 7f is not decoded
    store_check(5'd2, 6, "after_undefined");
    emit({20'd0, 5'd0, 7'(rv_pkg::OPCODE_JAL)}); // park on jal x0, 0
endtask

`endif

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam logic [31:0] RESET_PC = 32'h40;
    localparam int imem_words = 256;
    localparam int dmem_words = 512;
    localparam int timeout_cycles = 2000;
    localparam logic [31:0] seed = 32'd49407;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] imem [imem_words];
    logic [31:0] dmem [dmem_words];
    int          store_idx;
    int          errors;

    `include "rv_core_prog.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    rv_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    // both memories read combinationally
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[10:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[10:2]] <= dmem_wdata;
            store_idx <= store_idx + 1;
        end
    end

    assert property (@(posedge clk) dmem_we && store_idx < n_exp |->
                     dmem_addr == exp_addr[store_idx] && dmem_wdata == exp_data[store_idx])
        else begin
            errors++;
            $display("MISMATCH %s: expected %h at %h, actual %h at %h",
                     exp_name[$sampled(store_idx)], exp_data[$sampled(store_idx)],
                     exp_addr[$sampled(store_idx)], $sampled(dmem_wdata),
                     $sampled(dmem_addr));
        end
    assert property (@(posedge clk) dmem_we |-> store_idx < n_exp)
        else begin
            errors++;
            $display("store beyond the end of the program at %h", $sampled(dmem_addr));
        end
    assert property (@(posedge clk) reset |-> !dmem_we && !dmem_re)
        else begin
            errors++;
            $display("memory enable was high during reset");
        end
    assert property (@(posedge clk) $fell(reset) |-> imem_addr == RESET_PC)
        else begin
            errors++;
            $display("MISMATCH reset_pc: expected %h, actual %h", RESET_PC, $sampled(imem_addr));
        end

    initial begin
        logic [31:0] rng;
        logic [31:0] first_word;
        int          cycles;
        clk = 1'b0;
        reset = 1'b1;
        errors = 0;
        store_idx = 0;
        rng = seed;
        for (int i = 0; i < dmem_words; i++) begin
            rng = xorshift(rng);
            dmem[i] = rng;
        end
        for (int i = 0; i < imem_words; i++)
            imem[i] = enc_addi(5'd0, 5'd0, 12'(i)); // nop with the index as imm
        build_program();
        // a load, then a store, fetched while reset holds the pc
        first_word = imem[RESET_PC[9:2]];
        imem[RESET_PC[9:2]] = enc_r(7'd0, 5'd0, 5'd0, 3'b010, 5'd4, rv_pkg::OPCODE_LOAD);
        repeat (2) @(posedge clk);
        @(negedge clk);
        imem[RESET_PC[9:2]] = enc_r(7'd0, 5'd0, 5'd0, 3'b010, 5'd0, rv_pkg::OPCODE_STORE);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        imem[RESET_PC[9:2]] = first_word; // program proper starts here
        cycles = 0;
        while (store_idx < n_exp && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < n_exp) begin
            errors++;
            $display("timeout, program stalled after %0d of %0d stores", store_idx, n_exp);
        end
        repeat (3) @(posedge clk); // catch stray stores
        $display("errors: %0d, stores seen: %0d of %0d", errors, store_idx, n_exp);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+test
logic/rv_pkg.sv
logic/ctrl_if.sv
logic/control.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/execute.sv
logic/pc_unit.sv
logic/rv_core.sv
test/rv_core_tb.sv
